//--- verilog/crypto_target_pkg.sv
// Shared widths, typedefs and localparams for the crypto target
// Host bus request and cipher job structs, bank address map
package crypto_target_pkg;

    // Cipher and pipeline sizing
    localparam int NUM_ROUNDS     = 8;                         // One round per stage
    localparam int ROT_AMT        = 3;                         // Round rotation
    localparam int FLIGHT_W       = $clog2(NUM_ROUNDS + 1);    // Counts 0..NUM_ROUNDS

    // Host bus behaviour
    localparam int RD_HOLD_CYCLES = 3;                         // OE stretch after rd_n rises

    // Address map, bit 8 picks the input bank
    localparam int ADDR_SEL_BIT   = 8;
    localparam int IN_BANK_BYTES  = 16;                        // 0x100..0x10F, pt then key
    localparam int OUT_BANK_BYTES = 8;                         // 0x000..0x007, ciphertext
    localparam int IN_IDX_W       = $clog2(IN_BANK_BYTES);
    localparam int OUT_IDX_W      = $clog2(OUT_BANK_BYTES);

    typedef logic [8:0]          bus_addr_t;                   // Host address
    typedef logic [7:0]          bus_data_t;                   // Host data byte
    typedef logic [31:0]         word_t;                       // Cipher half-block
    typedef logic [63:0]         block_t;                      // Byte 0 is the LSB
    typedef logic [63:0]         key_t;
    typedef logic [FLIGHT_W-1:0] flight_cnt_t;                 // Jobs in flight

    // One host request as seen on a clock edge
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        logic      rd;                                         // Active high read
        logic      wr;                                         // Active high write
    } bus_req_t;

    // Job moving down the pipeline, key travels with it
    typedef struct packed {
        logic   valid;
        block_t state;
        key_t   key;
    } cipher_job_t;

endpackage

//--- verilog/target_bus.sv
// Host bus front end
// Turns active-low strobes into a request, registers read data, stretches OE
`timescale 1ns/1ps

module target_bus
    import crypto_target_pkg::*;
(
    input  logic      clk_buf,
    input  logic      rst,
    input  bus_addr_t addr,                 // Host address
    input  bus_data_t data_in,              // Write data from host
    input  logic      rd_n,                 // Low while host reads
    input  logic      wr_n,                 // Low while host writes
    input  bus_data_t rdata,                // Read mux result from banks
    output bus_req_t  req,                  // Request seen at this edge
    output bus_data_t data_out,             // Registered read data
    output logic      data_oe               // Board wrapper drives bus when high
);

    logic [RD_HOLD_CYCLES-1:0] rd_hold;     // Recent read history

    // Request built straight from pins, regs act on it at the edge
    always_comb begin
        req.addr  = addr;
        req.wdata = data_in;
        req.rd    = ~rd_n;
        req.wr    = ~wr_n;
    end

    // Read data lands one cycle after the rd_n-low sample
    always_ff @(posedge clk_buf) begin
        if (rst) begin
            data_out <= '0;
        end else if (req.rd) begin
            data_out <= rdata;              // Latch byte for this address
        end
    end

    // Shift in the read strobe so OE outlives rd_n
    always_ff @(posedge clk_buf) begin
        if (rst) begin
            rd_hold <= '0;
        end else begin
            rd_hold <= {rd_hold[RD_HOLD_CYCLES-2:0], req.rd};
        end
    end

    // High during read and for RD_HOLD_CYCLES after it ends
    assign data_oe = req.rd | (|rd_hold);

    // Host must never read and write in the same cycle
    a_no_rd_wr_overlap : assert property (
        @(posedge clk_buf) disable iff (rst)
        !(req.rd && req.wr)
    ) else $error("FAILED %0t: rd_n and wr_n both low", $time);

endmodule

//--- verilog/target_regs.sv
// Input and output register banks
// Address decode, read mux, job launch on trigger, ciphertext capture
`timescale 1ns/1ps

module target_regs
    import crypto_target_pkg::*;
(
    input  logic        clk_buf,
    input  logic        rst,
    input  bus_req_t    req,                // Host request this edge
    input  logic        trigger,            // One-cycle start strobe
    input  cipher_job_t job_out,            // Job leaving the last stage
    output bus_data_t   rdata,              // Byte at req.addr
    output cipher_job_t job_in              // Job entering the pipeline
);

    bus_data_t [IN_BANK_BYTES-1:0]  in_bank;    // Plaintext low 8, key high 8
    bus_data_t [OUT_BANK_BYTES-1:0] out_bank;   // Last ciphertext

    logic                    sel_in;            // Section bit
    logic [ADDR_SEL_BIT-1:0] offset;            // Address within section
    logic                    in_hit;
    logic                    out_hit;

    // Decode by section bit and range
    assign sel_in  = req.addr[ADDR_SEL_BIT];
    assign offset  = req.addr[ADDR_SEL_BIT-1:0];
    assign in_hit  = sel_in && (offset < IN_BANK_BYTES);
    assign out_hit = !sel_in && (offset < OUT_BANK_BYTES);

    // Input bank, host writable only
    always_ff @(posedge clk_buf) begin
        if (rst) begin
            in_bank <= '0;
        end else if (req.wr && in_hit) begin
            in_bank[offset[IN_IDX_W-1:0]] <= req.wdata;
        end
    end

    // Output bank, loaded by each finished job
    always_ff @(posedge clk_buf) begin
        if (rst) begin
            out_bank <= '0;
        end else if (job_out.valid) begin
            out_bank <= job_out.state;
        end
    end

    // Read mux, unmapped space reads zero
    always_comb begin
        if (in_hit) begin
            rdata = in_bank[offset[IN_IDX_W-1:0]];
        end else if (out_hit) begin
            rdata = out_bank[offset[OUT_IDX_W-1:0]];
        end else begin
            rdata = '0;
        end
    end

    // Snapshot of the bank goes in with the trigger
    always_comb begin
        job_in.valid = trigger;
        job_in.state = in_bank[7:0];                            // Plaintext bytes 0..7
        job_in.key   = in_bank[IN_BANK_BYTES-1:8];              // Key bytes 8..15
    end

endmodule

//--- verilog/arx_round.sv
// One registered ARX round stage
// Round key is the carried key rotated by 8*ROUND, low word XOR ROUND
`timescale 1ns/1ps

module arx_round
    import crypto_target_pkg::*;
#(
    parameter int ROUND = 0                 // Round index
) (
    input  logic        clk_buf,
    input  logic        rst,
    input  cipher_job_t job_d,              // Job from previous stage
    output cipher_job_t job_q               // Job after this round
);

    localparam int KEY_ROT = (8 * ROUND) % 64;  // Wraps for any ROUND

    key_t   key_rot;
    word_t  round_key;
    word_t  l_in;
    word_t  r_in;
    word_t  r_mix;                          // (R <<< ROT_AMT) + R
    block_t state_next;

    logic   valid_q;
    block_t state_q;
    key_t   key_q;

    assign key_rot   = (job_d.key << KEY_ROT) | (job_d.key >> (64 - KEY_ROT));
    assign round_key = key_rot[31:0] ^ word_t'(ROUND);

    assign l_in  = job_d.state[63:32];
    assign r_in  = job_d.state[31:0];
    assign r_mix = ((r_in << ROT_AMT) | (r_in >> (32 - ROT_AMT))) + r_in;    // Mod 2^32

    // New L is old R, new R mixes in the round function
    assign state_next = {r_in, l_in ^ (r_mix ^ round_key)};

    always_ff @(posedge clk_buf) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= job_d.valid;
        end
    end

    // Payload only loads with a real job
    always_ff @(posedge clk_buf) begin
        if (job_d.valid) begin
            state_q <= state_next;
            key_q   <= job_d.key;           // Key rides along unchanged
        end
    end

    assign job_q = '{valid: valid_q, state: state_q, key: key_q};

endmodule

//--- verilog/arx_pipeline.sv
// Chain of NUM_ROUNDS cipher stages
// In-flight job counter driving the scope capture trigger
`timescale 1ns/1ps

module arx_pipeline
    import crypto_target_pkg::*;
(
    input  logic        clk_buf,
    input  logic        rst,
    input  cipher_job_t job_in,             // New job, valid on trigger
    output cipher_job_t job_out,            // Finished job
    output logic        capture_trig        // High while any job is in flight
);

    cipher_job_t stage [NUM_ROUNDS+1];      // stage[i] feeds round i
    flight_cnt_t in_flight;

    assign stage[0] = job_in;

    for (genvar g = 0; g < NUM_ROUNDS; g++) begin : g_round
        arx_round #(
            .ROUND (g)
        ) round_inst (
            .clk_buf (clk_buf),
            .rst     (rst),
            .job_d   (stage[g]),
            .job_q   (stage[g+1])
        );
    end

    assign job_out = stage[NUM_ROUNDS];

    // Up when a job enters, down when the output bank stores one
    always_ff @(posedge clk_buf) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({job_in.valid, job_out.valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;        // Both or neither
            endcase
        end
    end

    assign capture_trig = (in_flight != '0);

    // With no back-pressure the stages bound the count
    a_flight_bound : assert property (
        @(posedge clk_buf) disable iff (rst)
        in_flight <= flight_cnt_t'(NUM_ROUNDS)
    ) else $error("FAILED %0t: %0d jobs in flight", $time, in_flight);

endmodule

//--- verilog/crypto_target_top.sv
// Crypto target top level
// Host bus front end, register banks and ARX pipeline
`timescale 1ns/1ps

module crypto_target_top
    import crypto_target_pkg::*;
(
    input  logic      clk_buf,
    input  logic      rst,
    input  bus_addr_t addr,
    input  bus_data_t data_in,
    input  logic      rd_n,
    input  logic      wr_n,
    input  logic      trigger,              // Start encryption
    output bus_data_t data_out,
    output logic      data_oe,
    output logic      capture_trig          // Scope framing
);

    bus_req_t    req;
    bus_data_t   rdata;
    cipher_job_t job_in;
    cipher_job_t job_out;

    target_bus bus_inst (
        .clk_buf  (clk_buf),
        .rst      (rst),
        .addr     (addr),
        .data_in  (data_in),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .rdata    (rdata),
        .req      (req),
        .data_out (data_out),
        .data_oe  (data_oe)
    );

    target_regs regs_inst (
        .clk_buf (clk_buf),
        .rst     (rst),
        .req     (req),
        .trigger (trigger),
        .job_out (job_out),
        .rdata   (rdata),
        .job_in  (job_in)
    );

    arx_pipeline pipe_inst (
        .clk_buf      (clk_buf),
        .rst          (rst),
        .job_in       (job_in),
        .job_out      (job_out),
        .capture_trig (capture_trig)
    );

endmodule

//--- verif/tb_clock.sv
// Free-running testbench clock
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20            // Full clock period
) (
    output logic clk_buf
);

    initial begin
        clk_buf = 1'b0;                     // First rising edge at half a period
    end

    always begin
        #(PERIOD_NS / 2);
        clk_buf = ~clk_buf;
    end

endmodule

//--- verif/crypto_target_tb.sv
// Crypto target testbench with host bus tasks, LFSR stimulus and reference ARX cipher
// Concurrent checks on read data, output enable and capture trigger, with timeout and report
`timescale 1ns/1ps

module crypto_target_tb
    import crypto_target_pkg::*;
();

    localparam int MAX_CYCLES = 3000;               // Tests need about 400 cycles
    localparam int NUM_KEYS   = 4;                  // Single-encryption runs

    logic      clk_buf;
    logic      rst;
    bus_addr_t addr;
    bus_data_t data_in;
    logic      rd_n;
    logic      wr_n;
    logic      trigger;
    bus_data_t data_out;
    logic      data_oe;
    logic      capture_trig;

    bus_data_t             in_model [IN_BANK_BYTES];    // Expected input bank
    block_t                ct_model;                    // Expected output bank
    bus_data_t             exp_rdata;                   // Byte the current read should return
    bus_data_t             last_exp;                    // exp_rdata one edge back
    bus_addr_t             last_addr;
    logic [NUM_ROUNDS-1:0] trig_hist;                   // Triggers over the last 8 edges
    logic [31:0]           lfsr;
    int                    cycles;
    int                    read_errs;
    int                    oe_errs;
    int                    trig_errs;

    tb_clock #(
        .PERIOD_NS (20)
    ) clock_inst (
        .clk_buf (clk_buf)
    );

    crypto_target_top crypto_target_top_inst (
        .clk_buf      (clk_buf),
        .rst          (rst),
        .addr         (addr),
        .data_in      (data_in),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .trigger      (trigger),
        .data_out     (data_out),
        .data_oe      (data_oe),
        .capture_trig (capture_trig)
    );

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Reference cipher with the key rotated one more byte each round
    function automatic block_t encrypt(block_t pt, key_t key);
        word_t l;
        word_t r;
        word_t f;
        key_t  k;
        l = pt[63:32];
        r = pt[31:0];
        k = key;
        for (int i = 0; i < NUM_ROUNDS; i++) begin
            f      = ({r[28:0], r[31:29]} + r) ^ (k[31:0] ^ word_t'(i));
            {l, r} = {r, l ^ f};                            // Swap halves and mix into R
            k      = {k[55:0], k[63:56]};
        end
        return {l, r};
    endfunction

    // Eight model bytes from base with byte 0 lowest
    function automatic logic [63:0] bank_word(int base);
        logic [63:0] w;
        for (int i = 0; i < 8; i++) begin
            w[8*i +: 8] = in_model[base + i];
        end
        return w;
    endfunction

    // Anything unmapped reads zero
    function automatic bus_data_t expect_byte(bus_addr_t a);
        if (a[8] && a[7:0] < IN_BANK_BYTES) begin
            return in_model[a[3:0]];
        end else if (!a[8] && a[7:0] < OUT_BANK_BYTES) begin
            return ct_model[8*a[2:0] +: 8];
        end
        return '0;
    endfunction

    task automatic host_write(bus_addr_t a, bus_data_t d);
        @(posedge clk_buf);
        addr    <= a;
        data_in <= d;
        wr_n    <= 1'b0;
        if (a[8] && a[7:0] < IN_BANK_BYTES) begin
            in_model[a[3:0]] = d;                           // Only the input bank takes writes
        end
        @(posedge clk_buf);
        wr_n <= 1'b1;
    endtask

    // rd_n stays low across count consecutive addresses
    task automatic host_read(bus_addr_t a, int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk_buf);
            addr      <= a + bus_addr_t'(i);
            rd_n      <= 1'b0;
            exp_rdata <= expect_byte(a + bus_addr_t'(i));
        end
        @(posedge clk_buf);
        rd_n <= 1'b1;
    endtask

    task automatic load_block(bus_addr_t base, logic [63:0] v);
        for (int i = 0; i < 8; i++) begin
            host_write(base + bus_addr_t'(i), v[8*i +: 8]);
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clk_buf);
        trigger  <= 1'b1;
        ct_model = encrypt(bank_word(0), bank_word(8));     // Bank snapshot at trigger
        @(posedge clk_buf);
        trigger <= 1'b0;
    endtask

    // Look at capture_trig on falling edges until the pipeline drains
    task automatic wait_idle();
        do begin
            @(negedge clk_buf);
        end while (capture_trig);
    endtask

    always @(posedge clk_buf) begin
        if (rst) begin
            trig_hist <= '0;
        end else begin
            trig_hist <= {trig_hist[NUM_ROUNDS-2:0], trigger};
        end
        last_exp  <= exp_rdata;
        last_addr <= addr;
    end

    // Read data one cycle after the rd_n-low sample
    a_read_data : assert property (
        @(posedge clk_buf) disable iff (rst)
        !rd_n |=> data_out == last_exp
    ) else begin
        read_errs++;
        $display("FAILED %0t: read of %h gave %h, expected %h",
                 $time, $sampled(last_addr), $sampled(data_out), $sampled(last_exp));
    end

    // OE with rd_n low and for 3 cycles after it rises
    a_oe_window : assert property (
        @(posedge clk_buf) disable iff (rst)
        data_oe == (!rd_n || !$past(rd_n, 1) || !$past(rd_n, 2) || !$past(rd_n, 3))
    ) else begin
        oe_errs++;
        $display("FAILED %0t: data_oe is %b outside its read window", $time, $sampled(data_oe));
    end

    // High for NUM_ROUNDS cycles after every trigger
    a_capture_window : assert property (
        @(posedge clk_buf) disable iff (rst)
        capture_trig == (|trig_hist)
    ) else begin
        trig_errs++;
        $display("FAILED %0t: capture_trig is %b, trigger history %b",
                 $time, $sampled(capture_trig), $sampled(trig_hist));
    end

    always @(posedge clk_buf) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        rst       <= 1'b1;
        addr      <= '0;
        data_in   <= '0;
        rd_n      <= 1'b1;
        wr_n      <= 1'b1;
        trigger   <= 1'b0;
        exp_rdata <= '0;
        lfsr      = 32'd71126;                              // Seed
        ct_model  = '0;
        cycles    = 0;
        read_errs = 0;
        oe_errs   = 0;
        trig_errs = 0;
        for (int i = 0; i < IN_BANK_BYTES; i++) begin
            in_model[i] = '0;
        end
        repeat (16) @(posedge clk_buf);
        rst <= 1'b0;

        host_read(9'h000, OUT_BANK_BYTES);                  // Output bank zero after reset

        load_block(9'h100, take_bits(64));                  // Plaintext
        load_block(9'h108, take_bits(64));                  // Key
        host_read(9'h100, IN_BANK_BYTES);                   // Long burst
        host_read(9'h10B, 1);                               // Single-cycle read for the OE tail
        repeat (5) @(posedge clk_buf);

        for (int n = 0; n < NUM_KEYS; n++) begin
            load_block(9'h108, take_bits(64));
            load_block(9'h100, take_bits(64));
            pulse_trigger();
            repeat (NUM_ROUNDS - 1) @(posedge clk_buf);     // Read starts at the store edge
            host_read(9'h000, OUT_BANK_BYTES);
        end

        // Two jobs in flight where the second one sees a new plaintext byte
        pulse_trigger();
        host_write(9'h100, bus_data_t'(take_bits(8)));
        pulse_trigger();
        wait_idle();
        host_read(9'h000, OUT_BANK_BYTES);

        host_write(9'h110, 8'hA5);                          // Past the input bank
        host_write(9'h010, 8'h5A);                          // Past the output bank
        host_read(9'h110, 1);
        host_read(9'h010, 1);
        host_read(9'h100, IN_BANK_BYTES);
        host_read(9'h000, OUT_BANK_BYTES);
        repeat (6) @(posedge clk_buf);                      // Let the last checks fire

        $display("Errors: %0d read data, %0d output enable, %0d capture trigger",
                 read_errs, oe_errs, trig_errs);
        if (read_errs + oe_errs + trig_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/crypto_target_pkg.sv
verilog/target_bus.sv
verilog/target_regs.sv
verilog/arx_round.sv
verilog/arx_pipeline.sv
verilog/crypto_target_top.sv
verif/tb_clock.sv
verif/crypto_target_tb.sv

//--- build.sh
#!/bin/sh
# Compile and run the crypto target testbench with Verilator, then look for the pass message
verilator --binary --timing --assert -Wno-fatal --top-module crypto_target_tb \
    -f build.f -o sim_tb || { echo "Result: build failed"; exit 1; }
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" && echo "Result: pass" || { echo "Result: fail"; exit 1; }
